//--- Makefile
# Verilator build for the fetch unit testbench

VERILATOR ?= verilator
TOP ?= tb_fetch
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_TEXT ?= TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard logic/*.sv sim/*.sv sim/*.svh)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- logic/fetch_pc_counter.sv
/*
 * fetch address register
 * redirect wins over advance, and with neither the address holds
 * advance must already exclude stall and redirect
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_counter (
	input wire logic clock,
	input wire logic reset,

	// consume condition from the miss controller
	input wire logic advance,

	// outside redirect, stands in for a pipeline flush
	input wire logic redirect,
	input wire logic [fetch_pkg::xlen-1:0] redirect_pc,

	output logic [fetch_pkg::xlen-1:0] pc
);

	import fetch_pkg::*;

	// address of the next sequential instruction
	logic [xlen-1:0] step_pc;

	assign step_pc = pc + xlen'(inst_bytes);

	////////////////////////////////////////////////////////////
	// pc register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			// fetch starts at address zero
			pc <= '0;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (advance) begin
			// one instruction consumed
			pc <= step_pc;
		end
		// otherwise hold, covers stall and miss
	end

endmodule

`default_nettype wire

//--- logic/fetch_pkg.sv
/*
 * shared widths, cache geometry and memory port codes for the fetch unit
 * cacheable addresses are assumed to lie below 64 KiB, so the tag is 8 bits
 * the memory port moves one 64-bit block per transaction
 */
`default_nettype none

package fetch_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	// address and instruction width
	localparam int xlen = 32;
	// one memory block, two instructions
	localparam int block_bits = 64;
	// pc step
	localparam int inst_bytes = 4;

	////////////////////////////////////////////////////////////
	// cache geometry
	////////////////////////////////////////////////////////////

	// byte offset inside a block
	localparam int offset_bits = 3;
	// line index
	localparam int index_bits = 5;
	localparam int cache_lines = 2 ** index_bits;
	// 16 address bits minus index and offset
	localparam int cache_tag_bits = 8;

	typedef logic [block_bits-1:0] mem_block_t;

	// zero means no tag, or a rejected request
	typedef logic [3:0] mem_tag_t;

	typedef logic [index_bits-1:0] cache_index_t;
	typedef logic [cache_tag_bits-1:0] cache_tag_t;

	// memory commands, store is never issued by fetch
	typedef enum logic [1:0] {
		mem_none = 2'h0,
		mem_load = 2'h1,
		mem_store = 2'h2
	} mem_command_t;

endpackage

`default_nettype wire

//--- logic/icache_mem.sv
/*
 * direct-mapped instruction cache storage, 32 lines of one block each
 * lookup is combinational, a fill is visible from the next cycle
 * pc bits above 16 do not take part in the tag compare
 */
`timescale 1ns/1ps
`default_nettype none

module icache_mem (
	input wire logic clock,
	input wire logic reset,

	// lookup address
	input wire logic [fetch_pkg::xlen-1:0] pc,

	// fill from the miss controller, data straight off the memory port
	input wire logic fill_en,
	input wire fetch_pkg::cache_index_t fill_index,
	input wire fetch_pkg::cache_tag_t fill_tag,
	input wire fetch_pkg::mem_block_t fill_data,

	output logic hit,
	output fetch_pkg::mem_block_t block
);

	import fetch_pkg::*;

	// per-line state
	logic [cache_lines-1:0] valid_bits;
	cache_tag_t tag_array [cache_lines];
	mem_block_t block_array [cache_lines];

	cache_index_t lookup_index;
	cache_tag_t lookup_tag;

	////////////////////////////////////////////////////////////
	// lookup
	////////////////////////////////////////////////////////////

	// pc fields: tag above index above byte offset
	assign lookup_index = pc[offset_bits +: index_bits];
	assign lookup_tag = pc[offset_bits+index_bits +: cache_tag_bits];

	assign hit = valid_bits[lookup_index] && (tag_array[lookup_index] == lookup_tag);
	// block is meaningless without hit
	assign block = block_array[lookup_index];

	////////////////////////////////////////////////////////////
	// fill
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			// empty cache after reset
			valid_bits <= '0;
		end else if (fill_en) begin
			valid_bits[fill_index] <= 1'b1;
		end
	end

	// tag and data arrays
	always_ff @(posedge clock) begin
		if (fill_en) begin
			tag_array[fill_index] <= fill_tag;
			block_array[fill_index] <= fill_data;
		end
	end

endmodule

`default_nettype wire

//--- logic/icache_miss_fsm.sv
/*
 * miss controller for the direct-mapped instruction cache
 * a zero response means rejected, and the load repeats next cycle
 * a redirect does not cancel an outstanding miss, the fill still completes
 * only one miss is outstanding at any time
 */
`timescale 1ns/1ps
`default_nettype none

module icache_miss_fsm (
	input wire logic clock,
	input wire logic reset,

	// lookup side
	input wire logic [fetch_pkg::xlen-1:0] pc,
	input wire logic hit,

	// consumer side
	input wire logic stall,
	input wire logic redirect,

	// memory answers
	input wire fetch_pkg::mem_tag_t mem2proc_response,
	input wire fetch_pkg::mem_tag_t mem2proc_tag,

	output logic inst_valid,
	output logic advance,

	// cache fill
	output logic fill_en,
	output fetch_pkg::cache_index_t fill_index,
	output fetch_pkg::cache_tag_t fill_tag,

	// memory requests
	output fetch_pkg::mem_command_t proc2mem_command,
	output logic [fetch_pkg::xlen-1:0] proc2mem_addr
);

	import fetch_pkg::*;

	typedef enum logic [1:0] {
		idle,
		request,
		wait_data
	} state_t;

	state_t state;
	state_t next_state;

	// block address of the line being fetched
	logic [xlen-1:0] miss_addr;
	// tag handed back when the load was accepted
	mem_tag_t saved_tag;

	logic miss;
	logic accepted;
	logic tag_match;

	////////////////////////////////////////////////////////////
	// decode of the current cycle
	////////////////////////////////////////////////////////////

	// instruction available only while no miss is in flight
	assign inst_valid = (state == idle) && hit;
	assign advance = inst_valid && !stall && !redirect;

	// miss only counts when pc is about to be used
	assign miss = (state == idle) && !hit && !stall && !redirect;

	// nonzero response in the request cycle
	assign accepted = (state == request) && (mem2proc_response != '0);

	// other tags on the port belong to someone else
	assign tag_match = (state == wait_data) && (mem2proc_tag == saved_tag);

	////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (miss) begin
					next_state = request;
				end
			end
			request: begin
				// rejected loads stay here and retry
				if (accepted) begin
					next_state = wait_data;
				end
			end
			wait_data: begin
				if (tag_match) begin
					next_state = idle;
				end
			end
			default: begin
				next_state = idle;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			saved_tag <= '0;
		end else begin
			state <= next_state;
			if (accepted) begin
				saved_tag <= mem2proc_response;
			end
		end
	end

	// block aligned miss address, index and tag are sliced from it
	always_ff @(posedge clock) begin
		if (miss) begin
			miss_addr <= {pc[xlen-1:offset_bits], {offset_bits{1'b0}}};
		end
	end

	////////////////////////////////////////////////////////////
	// outputs to memory and cache
	////////////////////////////////////////////////////////////

	assign proc2mem_command = (state == request) ? mem_load : mem_none;
	assign proc2mem_addr = miss_addr;

	// data is on mem2proc_data in the matching cycle
	assign fill_en = tag_match;
	assign fill_index = miss_addr[offset_bits +: index_bits];
	assign fill_tag = miss_addr[offset_bits+index_bits +: cache_tag_bits];

endmodule

`default_nettype wire

//--- logic/instruction_fetch.sv
/*
 * instruction fetch front end, single issue
 * an instruction is consumed when inst_valid is high with stall and redirect low
 * memory only ever sees loads of whole 64-bit blocks
 */
`timescale 1ns/1ps
`default_nettype none

module instruction_fetch (
	input wire logic clock,
	input wire logic reset,

	// consumer control
	input wire logic stall,
	input wire logic redirect,
	input wire logic [fetch_pkg::xlen-1:0] redirect_pc,

	// memory port
	input wire fetch_pkg::mem_tag_t mem2proc_response,
	input wire fetch_pkg::mem_block_t mem2proc_data,
	input wire fetch_pkg::mem_tag_t mem2proc_tag,

	// fetched instruction
	output logic [fetch_pkg::xlen-1:0] inst,
	output logic [fetch_pkg::xlen-1:0] inst_pc,
	output logic inst_valid,

	output fetch_pkg::mem_command_t proc2mem_command,
	output logic [fetch_pkg::xlen-1:0] proc2mem_addr
);

	import fetch_pkg::*;

	logic [xlen-1:0] pc;
	logic advance;

	// cache to controller
	logic hit;
	mem_block_t block;

	// controller to cache
	logic fill_en;
	cache_index_t fill_index;
	cache_tag_t fill_tag;

	fetch_pc_counter pc_counter_i (
		.clock(clock),
		.reset(reset),
		.advance(advance),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.pc(pc)
	);

	icache_miss_fsm miss_fsm_i (
		.clock(clock),
		.reset(reset),
		.pc(pc),
		.hit(hit),
		.stall(stall),
		.redirect(redirect),
		.mem2proc_response(mem2proc_response),
		.mem2proc_tag(mem2proc_tag),
		.inst_valid(inst_valid),
		.advance(advance),
		.fill_en(fill_en),
		.fill_index(fill_index),
		.fill_tag(fill_tag),
		.proc2mem_command(proc2mem_command),
		.proc2mem_addr(proc2mem_addr)
	);

	icache_mem icache_mem_i (
		.clock(clock),
		.reset(reset),
		.pc(pc),
		.fill_en(fill_en),
		.fill_index(fill_index),
		.fill_tag(fill_tag),
		.fill_data(mem2proc_data),
		.hit(hit),
		.block(block)
	);

	// pc bit 2 picks the word inside the block
	assign inst = pc[2] ? block[xlen +: xlen] : block[0 +: xlen];
	assign inst_pc = pc;

endmodule

`default_nettype wire

//--- sim/fetch_tb_defs.svh
/*
 * block contents rule and run lengths for the fetch testbench
 * addresses used by the tests stay below 32 KiB
 */
`ifndef FETCH_TB_DEFS_SVH
`define FETCH_TB_DEFS_SVH

// consumed instructions per test
localparam int num_tests = 4;
localparam int num_fetches = 300;
// longest random delay between accept and data, in cycles
localparam int max_mem_delay = 8;
// extra cycles per fetch allowed by the watchdog
localparam int cycle_margin = 24;

localparam logic [31:0] block_pattern = 32'h5a3c96e1;

// low word is block address xor pattern, high word its complement
function automatic logic [63:0] block_value(input logic [31:0] addr);
	logic [31:0] low;
	low = {addr[31:3], 3'b000} ^ block_pattern;
	return {~low, low};
endfunction

`endif

//--- sim/fetch_checker.sv
/*
 * reference model for the fetch unit, samples everything on the rising edge
 * expected pc, expected words and a model of cache residency
 * prints one line per test when end_test is seen
 */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_tb_defs.svh"

module fetch_checker (
	input wire logic clock,
	input wire logic reset,
	input wire logic stall,
	input wire logic redirect,
	input wire logic [31:0] redirect_pc,
	input wire fetch_pkg::mem_tag_t mem2proc_response,
	input wire fetch_pkg::mem_tag_t mem2proc_tag,
	input wire logic [31:0] inst,
	input wire logic [31:0] inst_pc,
	input wire logic inst_valid,
	input wire fetch_pkg::mem_command_t proc2mem_command,
	input wire logic [31:0] proc2mem_addr,
	input wire logic end_test,
	input int test_index,
	output int fetch_count,
	output int check_count,
	output int error_count
);

	import fetch_pkg::*;

	logic [31:0] exp_pc;
	int test_errors;

	// model cache residency
	logic [cache_lines-1:0] model_valid;
	logic [7:0] model_tag [cache_lines];
	logic [4:0] idx;

	// accepted load waiting for data
	logic pend;
	mem_tag_t pend_tag;
	logic [31:0] pend_addr;

	// block the next load must fetch
	logic [31:0] miss_block;

	logic reset_seen;
	logic first_after_reset;
	logic prev_stall;
	logic prev_redirect;
	logic prev_valid;
	logic [31:0] prev_pc;
	logic [31:0] prev_inst;

	function automatic logic [31:0] expected_inst(input logic [31:0] pc);
		logic [63:0] blk;
		blk = block_value(pc);
		return pc[2] ? blk[63:32] : blk[31:0];
	endfunction

	task automatic mismatch(input string msg);
		$display("MISMATCH at %0t: %s", $time, msg);
		error_count++;
		test_errors++;
	endtask

	// port must be quiet during and right after reset
	task automatic check_reset_outputs();
		check_count++;
		if (proc2mem_command !== mem_none)
			mismatch($sformatf("command %0d in reset", proc2mem_command));
		if (inst_valid !== 1'b0)
			mismatch("inst_valid high in reset");
	endtask

	initial begin
		fetch_count = 0;
		check_count = 0;
		error_count = 0;
		test_errors = 0;
		reset_seen = 1'b0;
	end

	always @(posedge clock) begin
		if (reset) begin
			if (reset_seen)
				check_reset_outputs();
			reset_seen = 1'b1;
			first_after_reset = 1'b1;
			exp_pc = '0;
			model_valid = '0;
			pend = 1'b0;
			miss_block = '0;
			prev_stall = 1'b0;
			prev_redirect = 1'b0;
			prev_valid = 1'b0;
		end else begin
			if (first_after_reset)
				check_reset_outputs();
			first_after_reset = 1'b0;

			// a miss in idle is fetched from the block holding exp_pc
			if (proc2mem_command != mem_load && !pend && !inst_valid && !stall && !redirect)
				miss_block = {exp_pc[31:3], 3'b000};

			////////////////////////////////////////////////////////////
			// memory side and residency
			////////////////////////////////////////////////////////////
			if (proc2mem_command == mem_load) begin
				check_count++;
				if (proc2mem_addr !== miss_block)
					mismatch($sformatf("load of %h, expected %h", proc2mem_addr, miss_block));
				idx = proc2mem_addr[7:3];
				if (model_valid[idx] && model_tag[idx] == proc2mem_addr[15:8])
					mismatch($sformatf("load of resident block %h", proc2mem_addr));
				if (mem2proc_response != '0) begin
					pend = 1'b1;
					pend_tag = mem2proc_response;
					pend_addr = proc2mem_addr;
				end
			end else if (pend && mem2proc_tag == pend_tag) begin
				// line becomes resident at this edge
				idx = pend_addr[7:3];
				model_valid[idx] = 1'b1;
				model_tag[idx] = pend_addr[15:8];
				pend = 1'b0;
			end

			// held pc and word under stall
			if (prev_stall && !prev_redirect) begin
				check_count++;
				if (inst_pc !== prev_pc)
					mismatch($sformatf("pc moved under stall, %h to %h", prev_pc, inst_pc));
				if (prev_valid && inst_valid && inst !== prev_inst)
					mismatch($sformatf("inst changed under stall at pc %h", inst_pc));
			end

			////////////////////////////////////////////////////////////
			// consumed instructions
			////////////////////////////////////////////////////////////
			if (inst_valid && !stall && !redirect) begin
				check_count++;
				fetch_count++;
				if (inst_pc !== exp_pc)
					mismatch($sformatf("pc %h, expected %h", inst_pc, exp_pc));
				else if (inst !== expected_inst(exp_pc))
					mismatch($sformatf("inst %h at pc %h, expected %h",
						inst, exp_pc, expected_inst(exp_pc)));
				exp_pc = exp_pc + 32'd4;
			end
			// redirect wins, even over an outstanding miss
			if (redirect)
				exp_pc = redirect_pc;

			prev_stall = stall;
			prev_redirect = redirect;
			prev_valid = inst_valid;
			prev_pc = inst_pc;
			prev_inst = inst;

			if (end_test) begin
				$display("test %0d %s: %0d fetches, %0d errors", test_index,
					(test_errors == 0) ? "ok" : "failed", fetch_count, test_errors);
				fetch_count = 0;
				test_errors = 0;
			end
		end
	end

endmodule

`default_nettype wire

//--- sim/fetch_properties.sv
/*
 * concurrent checks on the miss controller, bound into icache_miss_fsm
 * the accepted tag and the outstanding load are tracked from the memory port
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_properties (
	input wire logic clock,
	input wire logic reset,
	input wire logic inst_valid,
	input wire logic fill_en,
	input wire fetch_pkg::mem_command_t proc2mem_command,
	input wire logic [fetch_pkg::xlen-1:0] proc2mem_addr,
	input wire fetch_pkg::mem_tag_t mem2proc_response,
	input wire fetch_pkg::mem_tag_t mem2proc_tag
);

	import fetch_pkg::*;

	// tag that memory handed out for the load in flight
	mem_tag_t granted_tag;
	// accepted, data not yet filled
	logic in_flight;

	always_ff @(posedge clock) begin
		if (reset) begin
			granted_tag <= '0;
			in_flight <= 1'b0;
		end else if (proc2mem_command == mem_load && mem2proc_response != '0) begin
			granted_tag <= mem2proc_response;
			in_flight <= 1'b1;
		end else if (fill_en) begin
			in_flight <= 1'b0;
		end
	end

	// no instruction is offered while a miss is in flight
	no_load_with_valid: assert property (@(posedge clock) disable iff (reset)
		!(inst_valid && (proc2mem_command == mem_load || in_flight)))
		else $error("inst_valid high while a load is outstanding");

	// whole blocks only
	load_aligned: assert property (@(posedge clock) disable iff (reset)
		(proc2mem_command == mem_load) |-> (proc2mem_addr[offset_bits-1:0] == '0))
		else $error("load address is not block aligned");

	// a rejected load comes back next cycle for the same block
	load_retried: assert property (@(posedge clock) disable iff (reset)
		(proc2mem_command == mem_load && mem2proc_response == '0)
		|=> (proc2mem_command == mem_load && $stable(proc2mem_addr)))
		else $error("rejected load was not repeated");

	fill_on_own_tag: assert property (@(posedge clock) disable iff (reset)
		fill_en |-> (in_flight && mem2proc_tag == granted_tag))
		else $error("cache fill without the granted tag on the port");

endmodule

bind icache_miss_fsm fetch_properties props_i (
	.clock(clock),
	.reset(reset),
	.inst_valid(inst_valid),
	.fill_en(fill_en),
	.proc2mem_command(proc2mem_command),
	.proc2mem_addr(proc2mem_addr),
	.mem2proc_response(mem2proc_response),
	.mem2proc_tag(mem2proc_tag)
);

`default_nettype wire

//--- sim/tb_fetch.sv
/*
 * testbench for instruction_fetch
 * inputs change on the falling edge, memory model runs in the same process
 * test 0 plain, 1 stall, 2 redirect, 3 both
 */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_tb_defs.svh"

module tb_fetch;

	import fetch_pkg::*;

	localparam int clock_period = 20;
	localparam int reset_cycles = 10;
	localparam longint watchdog_cycles =
		longint'(num_tests) * num_fetches * (max_mem_delay + cycle_margin) + reset_cycles;

	logic clock;
	logic reset;
	logic stall;
	logic redirect;
	logic [31:0] redirect_pc;
	mem_tag_t mem2proc_response;
	mem_tag_t mem2proc_tag;
	mem_block_t mem2proc_data;

	logic [31:0] inst;
	logic [31:0] inst_pc;
	logic inst_valid;
	mem_command_t proc2mem_command;
	logic [31:0] proc2mem_addr;

	logic end_test;
	int test_index;
	int fetch_count;
	int check_count;
	int error_count;

	logic [31:0] rng_state;

	// memory model, one load outstanding
	logic pending;
	mem_tag_t pend_tag;
	mem_tag_t next_tag;
	logic [31:0] pend_addr;
	int pend_delay;

	instruction_fetch dut_i (
		.clock(clock),
		.reset(reset),
		.stall(stall),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.mem2proc_response(mem2proc_response),
		.mem2proc_data(mem2proc_data),
		.mem2proc_tag(mem2proc_tag),
		.inst(inst),
		.inst_pc(inst_pc),
		.inst_valid(inst_valid),
		.proc2mem_command(proc2mem_command),
		.proc2mem_addr(proc2mem_addr)
	);

	fetch_checker checker_i (
		.clock(clock),
		.reset(reset),
		.stall(stall),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.mem2proc_response(mem2proc_response),
		.mem2proc_tag(mem2proc_tag),
		.inst(inst),
		.inst_pc(inst_pc),
		.inst_valid(inst_valid),
		.proc2mem_command(proc2mem_command),
		.proc2mem_addr(proc2mem_addr),
		.end_test(end_test),
		.test_index(test_index),
		.fetch_count(fetch_count),
		.check_count(check_count),
		.error_count(error_count)
	);

	always #(clock_period / 2) clock = ~clock;

	function automatic logic [31:0] xorshift(input logic [31:0] value);
		logic [31:0] x;
		x = value;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic roll(output logic [31:0] value);
		rng_state = xorshift(rng_state);
		value = rng_state;
	endtask

	////////////////////////////////////////////////////////////
	// memory model
	////////////////////////////////////////////////////////////

	task automatic model_memory();
		logic [31:0] r;
		roll(r);
		mem2proc_response = '0;
		mem2proc_tag = '0;
		// garbage unless the right tag is driven
		mem2proc_data = {r, xorshift(r)};
		if (pending) begin
			if (pend_delay == 0) begin
				mem2proc_tag = pend_tag;
				mem2proc_data = block_value(pend_addr);
				pending = 1'b0;
			end else begin
				pend_delay--;
				if (r[3:0] < 4'd5)
					mem2proc_tag = (pend_tag == 4'd15) ? 4'd1 : pend_tag + 4'd1;
			end
		end else if (proc2mem_command == mem_load) begin
			// a quarter of the loads are rejected
			if (r[7:6] != 2'b00) begin
				mem2proc_response = next_tag;
				pending = 1'b1;
				pend_tag = next_tag;
				pend_addr = proc2mem_addr;
				pend_delay = int'(r[15:12]) % (max_mem_delay + 1);
				next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
			end
		end else if (r[3:0] < 4'd3) begin
			mem2proc_tag = r[19:16];
		end
	endtask

	task automatic drive_control(input int test);
		logic [31:0] r;
		roll(r);
		stall = 1'b0;
		redirect = 1'b0;
		// word aligned, below 32 KiB
		redirect_pc = {17'b0, r[14:2], 2'b00};
		if (test == 1 || test == 3)
			stall = (r[31:29] < 3'd3);
		if (test >= 2)
			redirect = (r[28:24] == 5'd0);
	endtask

	task automatic step_cycle(input int test);
		@(negedge clock);
		model_memory();
		drive_control(test);
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		stall = 1'b0;
		redirect = 1'b0;
		redirect_pc = '0;
		mem2proc_response = '0;
		mem2proc_tag = '0;
		mem2proc_data = '0;
		end_test = 1'b0;
		test_index = 0;
		rng_state = 32'hc280c94d;
		pending = 1'b0;
		pend_tag = '0;
		next_tag = 4'd1;
		pend_addr = '0;
		pend_delay = 0;

		repeat (reset_cycles) @(negedge clock);
		reset = 1'b0;

		for (int t = 0; t < num_tests; t++) begin
			test_index = t;
			while (fetch_count < num_fetches)
				step_cycle(t);
			// one quiet cycle marks the end of the test
			step_cycle(t);
			stall = 1'b1;
			redirect = 1'b0;
			end_test = 1'b1;
			step_cycle(t);
			end_test = 1'b0;
		end

		$display("tests %0d, checks %0d, errors %0d", num_tests, check_count, error_count);
		if (error_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(watchdog_cycles * clock_period);
		$display("timeout: fetch stopped delivering instructions");
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+sim
logic/fetch_pkg.sv
logic/fetch_pc_counter.sv
logic/icache_miss_fsm.sv
logic/icache_mem.sv
logic/instruction_fetch.sv
sim/fetch_properties.sv
sim/fetch_checker.sv
sim/tb_fetch.sv
